// File: rom_loader.f
+incdir+.
mem_req_pkg.sv
rom_layout_pkg.sv
rom_image_parser.sv
req_queue.sv
sdram_prog_writer.sv
rom_loader.sv
tb_rom_loader.sv

// File: rom_loader_patterns.hex
// kind bank addr mask data, one record per line, mask active low (1 = high half, 2 = low half)
// kind 0 host byte, 1 SDRAM write, 2 PROM write, 3 config write, F end of file
// start table: sound at 1 KB, PCM at 2 KB, graphics at 3 KB, Q-sound at 5 KB
0 0 00000000 0 01
0 0 00000001 0 00
0 0 00000002 0 02
0 0 00000003 0 00
0 0 00000004 0 03
0 0 00000005 0 00
0 0 00000006 0 05
0 0 00000007 0 00
// board config, byte 15 enables decryption of odd CPU bytes
0 0 00000008 0 11
0 0 00000009 0 22
0 0 0000000A 0 33
0 0 0000000B 0 44
0 0 0000000C 0 55
0 0 0000000D 0 66
0 0 0000000E 0 77
0 0 0000000F 0 C3
// bulk bytes: CPU, sound, PCM, graphics, Q-sound
0 0 00000010 0 12
0 0 00000011 0 34
0 0 00000018 0 5A
0 0 00000019 0 A5
0 0 0000001D 0 FF
0 0 00000413 0 82
0 0 00000814 0 93
0 0 00000C11 0 C2
0 0 00001013 0 C3
0 0 00001410 0 E1
0 0 00001417 0 E3
// expected config writes
3 0 00000008 0 11
3 0 00000009 0 22
3 0 0000000A 0 33
3 0 0000000B 0 44
3 0 0000000C 0 55
3 0 0000000D 0 66
3 0 0000000E 0 77
3 0 0000000F 0 C3
// expected CPU writes, words 4 and 6 odd are decrypted
1 3 00000000 1 12
1 3 00000000 2 34
1 3 00000004 1 5A
1 3 00000004 2 53
1 3 00000006 2 6A
// sound and PCM share bank 1, graphics in bank 2
1 1 00000001 2 82
1 1 00000002 1 93
1 2 00000000 2 C2
1 2 00000201 2 C3
// Q-sound PROM keeps the byte offset
2 0 00000000 0 E1
2 0 00000007 0 E3
F 0 00000000 0 00

// File: tb_rom_loader.sv
// ROM loader testbench
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module tb_rom_loader;

    localparam int REC_WORDS = 5;    // kind, bank, addr, mask, data
    localparam int MAX_RECS  = 64;
    localparam int K_BYTE    = 0;
    localparam int K_SDRAM   = 1;
    localparam int K_PROM    = 2;
    localparam int K_CFG     = 3;
    localparam int K_END     = 15;

    logic                              clk;
    logic                              reset;
    logic                              downloading;
    logic [`LDR_IOCTL_AW-1:0]          ioctl_addr;
    logic [7:0]                        ioctl_data;
    logic                              ioctl_wr;
    logic                              prog_rdy;
    logic                              dl_stall;
    logic [`LDR_PROG_AW-1:0]           prog_addr;
    logic [15:0]                       prog_data;
    logic [1:0]                        prog_mask;
    logic [1:0]                        prog_ba;
    logic                              prog_we;
    logic                              prom_we;
    logic                              cfg_we;
    logic [$clog2(`LDR_HDR_BYTES)-1:0] cfg_addr;
    logic [7:0]                        cfg_data;

    logic [31:0] pat_mem [REC_WORDS*MAX_RECS];
    int          str_rec[$];    // host byte records
    int          exp_rec[$];    // expected writes, in strobe order
    int          exp_idx;
    int          errors;
    logic        loaded;
    logic        stall_seen;
    logic [7:0]  lfsr;

    rom_loader u_rom_loader (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .prog_rdy    (prog_rdy),
        .dl_stall    (dl_stall),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_ba     (prog_ba),
        .prog_we     (prog_we),
        .prom_we     (prom_we),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] rec_word(input int rec, input int k);
        return pat_mem[rec*REC_WORDS + k];
    endfunction

    function automatic string kind_name(input int k);
        case (k)
            K_SDRAM: return "SDRAM";
            K_PROM:  return "PROM";
            K_CFG:   return "config";
            default: return "unknown";
        endcase
    endfunction

    // Galois LFSR, taps 8 6 5 4
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return s[0] ? (s >> 1) ^ 8'hB8 : s >> 1;
    endfunction

    task automatic draw_delay(output int d);
        d = 0;
        repeat (2) begin    // one step per bit
            d = (d << 1) | int'(lfsr[0]);
            lfsr = lfsr_next(lfsr);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_write(input int kind, input logic [31:0] bank,
                               input logic [31:0] addr, input logic [31:0] mask,
                               input logic [31:0] data);
        int         r;
        logic [7:0] b;
        assert (exp_idx < exp_rec.size()) else begin
            $display("%0t: extra %s write after the last expected one", $time, kind_name(kind));
            errors++;
        end
        if (exp_idx < exp_rec.size()) begin
            r = exp_rec[exp_idx];
            b = rec_word(r, 4);
            assert (rec_word(r, 0) == kind) else begin
                $display("%0t: write %0d came as %s but %s was expected", $time, exp_idx,
                         kind_name(kind), kind_name(rec_word(r, 0)));
                errors++;
            end
            exp_idx++;
            if (rec_word(r, 0) == kind && kind == K_CFG) begin
                compare_field("cfg_addr", addr, rec_word(r, 2));
                compare_field("cfg_data", data, b);
            end else if (rec_word(r, 0) == kind) begin
                if (kind == K_SDRAM) begin
                    compare_field("prog_ba", bank, rec_word(r, 1));
                    compare_field("prog_mask", mask, rec_word(r, 3));
                end
                compare_field("prog_addr", addr, rec_word(r, 2));
                compare_field("prog_data", data, {b, b});   // byte on both halves
            end
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (!reset) begin
            if (dl_stall)
                stall_seen = 1'b1;
            if (cfg_we)
                check_write(K_CFG, '0, cfg_addr, '0, cfg_data);
            if (prom_we)
                check_write(K_PROM, '0, prog_addr, '0, prog_data);
            if (prog_we && prog_rdy)    // handshake ends on the next edge
                check_write(K_SDRAM, prog_ba, prog_addr, prog_mask, prog_data);
        end
    end

    // SDRAM ready after 0 to 3 cycles
    initial begin : ready_driver
        int d;
        prog_rdy = 1'b0;
        lfsr     = 8'd27;
        forever begin
            @(posedge clk);
            #1;
            if (prog_we && !prog_rdy) begin
                draw_delay(d);
                repeat (d) begin
                    @(posedge clk);
                    #1;
                end
                prog_rdy = 1'b1;
            end else begin
                prog_rdy = 1'b0;
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (str_rec.size() * 20) @(posedge clk);
        $display("timeout with %0d of %0d expected writes seen", exp_idx, exp_rec.size());
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        int n;
        reset       = 1'b1;
        downloading = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        ioctl_wr    = 1'b0;
        exp_idx     = 0;
        errors      = 0;
        stall_seen  = 1'b0;
        $readmemh("rom_loader_patterns.hex", pat_mem);
        n = 0;
        while (n < MAX_RECS && rec_word(n, 0) !== K_END) begin
            if (rec_word(n, 0) == K_BYTE)
                str_rec.push_back(n);
            else
                exp_rec.push_back(n);
            n++;
        end
        assert (n < MAX_RECS && str_rec.size() > 0) else begin
            $display("pattern file missing or without end record");
            errors++;
        end
        loaded = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;
        compare_field("prog_we", prog_we, 0);
        compare_field("prom_we", prom_we, 0);
        compare_field("cfg_we", cfg_we, 0);
        compare_field("dl_stall", dl_stall, 0);

        downloading = 1'b1;
        foreach (str_rec[i]) begin
            @(posedge clk);
            #1;
            while (dl_stall) begin    // host holds off
                ioctl_wr = 1'b0;
                @(posedge clk);
                #1;
            end
            ioctl_addr = `LDR_IOCTL_AW'(rec_word(str_rec[i], 2));
            ioctl_data = 8'(rec_word(str_rec[i], 4));
            ioctl_wr   = 1'b1;
        end
        @(posedge clk);
        #1;
        ioctl_wr = 1'b0;

        wait (exp_idx == exp_rec.size());
        repeat (20) @(posedge clk);    // room for stray writes
        #1;
        downloading = 1'b0;
        assert (stall_seen) else begin
            $display("dl_stall never rose while ready was delayed");
            errors++;
        end

        $display("%0d of %0d writes checked, %0d errors", exp_idx, exp_rec.size(), errors);
        if (errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: rom_loader.sv
// ROM download loader top
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module rom_loader
    import mem_req_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    input  logic [`LDR_IOCTL_AW-1:0]          ioctl_addr,
    input  logic [7:0]                        ioctl_data,
    input  logic                              ioctl_wr,
    input  logic                              prog_rdy,
    output logic                              dl_stall,
    output logic [`LDR_PROG_AW-1:0]           prog_addr,
    output logic [15:0]                       prog_data,
    output logic [1:0]                        prog_mask,
    output logic [1:0]                        prog_ba,
    output logic                              prog_we,
    output logic                              prom_we,
    output logic                              cfg_we,
    output logic [$clog2(`LDR_HDR_BYTES)-1:0] cfg_addr,
    output logic [7:0]                        cfg_data
);

    // parser to queue
    logic                    req_push;
    logic [`LDR_PROG_AW-1:0] req_addr;
    logic [7:0]              req_data;
    logic [1:0]              req_mask;
    bank_t                   req_bank;
    req_kind_t               req_kind;

    // queue to writer
    logic                    q_empty;
    logic                    q_pop;
    logic [`LDR_PROG_AW-1:0] head_addr;
    logic [7:0]              head_data;
    logic [1:0]              head_mask;
    bank_t                   head_bank;
    req_kind_t               head_kind;

    logic                    credit_ret;   // writer back to parser

    rom_image_parser u_parser (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .ioctl_wr    (ioctl_wr),
        .credit_ret  (credit_ret),
        .dl_stall    (dl_stall),
        .req_push    (req_push),
        .req_addr    (req_addr),
        .req_data    (req_data),
        .req_mask    (req_mask),
        .req_bank    (req_bank),
        .req_kind    (req_kind),
        .cfg_we      (cfg_we),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data)
    );

    req_queue u_queue (
        .clk       (clk),
        .reset     (reset),
        .push      (req_push),
        .in_addr   (req_addr),
        .in_data   (req_data),
        .in_mask   (req_mask),
        .in_bank   (req_bank),
        .in_kind   (req_kind),
        .pop       (q_pop),
        .empty     (q_empty),
        .head_addr (head_addr),
        .head_data (head_data),
        .head_mask (head_mask),
        .head_bank (head_bank),
        .head_kind (head_kind)
    );

    sdram_prog_writer u_writer (
        .clk        (clk),
        .reset      (reset),
        .empty      (q_empty),
        .head_addr  (head_addr),
        .head_data  (head_data),
        .head_mask  (head_mask),
        .head_bank  (head_bank),
        .head_kind  (head_kind),
        .prog_rdy   (prog_rdy),
        .pop        (q_pop),
        .credit_ret (credit_ret),
        .prog_addr  (prog_addr),
        .prog_data  (prog_data),
        .prog_mask  (prog_mask),
        .prog_ba    (prog_ba),
        .prog_we    (prog_we),
        .prom_we    (prom_we)
    );

endmodule

`default_nettype wire

// File: sdram_prog_writer.sv
// SDRAM programming port writer
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module sdram_prog_writer
    import mem_req_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    empty,
    input  logic [`LDR_PROG_AW-1:0] head_addr,
    input  logic [7:0]              head_data,
    input  logic [1:0]              head_mask,
    input  bank_t                   head_bank,
    input  req_kind_t               head_kind,
    input  logic                    prog_rdy,
    output logic                    pop,
    output logic                    credit_ret,
    output logic [`LDR_PROG_AW-1:0] prog_addr,
    output logic [15:0]             prog_data,
    output logic [1:0]              prog_mask,   // active low
    output logic [1:0]              prog_ba,
    output logic                    prog_we,
    output logic                    prom_we      // Q-sound internal ROM
);

    typedef enum logic {
        ST_IDLE,
        ST_WAIT_RDY
    } state_t;

    state_t     state;
    logic [7:0] data_r;

    assign pop       = state == ST_IDLE && !empty;
    assign prog_data = {2{data_r}};   // same byte on both halves, mask picks one

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= ST_IDLE;
            prog_we    <= 1'b0;
            prom_we    <= 1'b0;
            credit_ret <= 1'b0;
        end else begin
            prom_we    <= 1'b0;
            credit_ret <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (!empty) begin
                        if (head_kind == KIND_PROM) begin
                            prom_we    <= 1'b1;
                            credit_ret <= 1'b1;   // PROM write done in one cycle
                        end else begin
                            prog_we <= 1'b1;
                            state   <= ST_WAIT_RDY;
                        end
                    end
                end
                ST_WAIT_RDY: begin
                    if (prog_rdy) begin
                        prog_we    <= 1'b0;
                        credit_ret <= 1'b1;
                        state      <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // request fields latched on pop
    always_ff @(posedge clk) begin
        if (pop) begin
            prog_addr <= head_addr;
            data_r    <= head_data;
            prog_mask <= head_mask;
            prog_ba   <= head_bank;
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (reset)
        prog_we && !prog_rdy |=> $stable(prog_addr));

endmodule

`default_nettype wire

// File: req_queue.sv
// write request FIFO
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module req_queue
    import mem_req_pkg::*;
(
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  logic [`LDR_PROG_AW-1:0] in_addr,
    input  logic [7:0]              in_data,
    input  logic [1:0]              in_mask,
    input  bank_t                   in_bank,
    input  req_kind_t               in_kind,
    input  logic                    pop,
    output logic                    empty,
    output logic [`LDR_PROG_AW-1:0] head_addr,
    output logic [7:0]              head_data,
    output logic [1:0]              head_mask,
    output bank_t                   head_bank,
    output req_kind_t               head_kind
);

    localparam int DEPTH = `LDR_QUEUE_DEPTH;
    localparam int PTRW  = $clog2(DEPTH);
    localparam int CNTW  = $clog2(DEPTH + 1);

    logic [`LDR_PROG_AW-1:0] addr_mem [DEPTH];
    logic [7:0]              data_mem [DEPTH];
    logic [1:0]              mask_mem [DEPTH];
    bank_t                   bank_mem [DEPTH];
    req_kind_t               kind_mem [DEPTH];
    logic [PTRW-1:0]         wr_ptr;
    logic [PTRW-1:0]         rd_ptr;
    logic [CNTW-1:0]         count;
    logic                    full;

    assign empty = count == '0;
    assign full  = count == CNTW'(DEPTH);

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr == PTRW'(DEPTH - 1) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr == PTRW'(DEPTH - 1) ? '0 : rd_ptr + 1'b1;
            count <= count + CNTW'(push) - CNTW'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            addr_mem[wr_ptr] <= in_addr;
            data_mem[wr_ptr] <= in_data;
            mask_mem[wr_ptr] <= in_mask;
            bank_mem[wr_ptr] <= in_bank;
            kind_mem[wr_ptr] <= in_kind;
        end
    end

    // head is read straight from the slot
    assign head_addr = addr_mem[rd_ptr];
    assign head_data = data_mem[rd_ptr];
    assign head_mask = mask_mem[rd_ptr];
    assign head_bank = bank_mem[rd_ptr];
    assign head_kind = kind_mem[rd_ptr];

    // credits upstream must keep the queue from overflowing
    a_no_overflow: assert property (@(posedge clk) disable iff (reset) full |-> !push);
    a_no_underflow: assert property (@(posedge clk) disable iff (reset) empty |-> !pop);

endmodule

`default_nettype wire

// File: rom_image_parser.sv
// ROM image parser
`timescale 1ns/1ps
`default_nettype none
`include "loader_defs.svh"

module rom_image_parser
    import rom_layout_pkg::*, mem_req_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              downloading,
    input  logic [`LDR_IOCTL_AW-1:0]          ioctl_addr,
    input  logic [7:0]                        ioctl_data,
    input  logic                              ioctl_wr,
    input  logic                              credit_ret,
    output logic                              dl_stall,
    output logic                              req_push,
    output logic [`LDR_PROG_AW-1:0]           req_addr,
    output logic [7:0]                        req_data,
    output logic [1:0]                        req_mask,   // active low
    output bank_t                             req_bank,
    output req_kind_t                         req_kind,
    output logic                              cfg_we,
    output logic [$clog2(`LDR_HDR_BYTES)-1:0] cfg_addr,
    output logic [7:0]                        cfg_data
);

    localparam int AW = `LDR_IOCTL_AW;
    localparam int PW = `LDR_PROG_AW;
    localparam int CW = $clog2(`LDR_QUEUE_DEPTH + 1);
    localparam logic [AW-1:0] HDR_END   = AW'(`LDR_HDR_BYTES);
    localparam logic [AW-1:0] START_END = AW'(`LDR_START_BYTES);
    localparam logic [AW-1:0] CFG_POS   = AW'(`LDR_CFG_BYTE);
    localparam logic [7:0][7:0] DEC_XOR = {
        `LDR_DEC_XOR_7, `LDR_DEC_XOR_6, `LDR_DEC_XOR_5, `LDR_DEC_XOR_4,
        `LDR_DEC_XOR_3, `LDR_DEC_XOR_2, `LDR_DEC_XOR_1, `LDR_DEC_XOR_0
    };

    start_table_u    starts;
    region_t         region;
    bank_t           bank;
    logic [AW-1:0]   bulk_addr;
    logic [AW-1:0]   rel_addr;     // byte offset inside the region
    logic [15:0]     kb_idx;       // 1 KB index of the bulk offset
    logic [15:0]     reg_start;
    logic [PW-1:0]   reg_ofs;
    logic [PW-1:0]   word_addr;
    logic [7:0]      dec_data;
    logic            dec_hit;
    logic            dec_en;
    logic            dec_sel;
    logic            is_start;
    logic            is_cfg;
    logic            is_bulk;
    logic            take;
    logic [CW-1:0]   credits;

    assign bulk_addr = ioctl_addr - HDR_END;
    assign kb_idx    = 16'(bulk_addr[AW-1:10]);
    assign is_start  = ioctl_addr < START_END;
    assign is_cfg    = !is_start && ioctl_addr < HDR_END;
    assign is_bulk   = ioctl_addr >= HDR_END;
    assign take      = ioctl_wr && is_bulk;    // spends one credit

    // regions are laid out in start order
    always_comb begin
        if (!is_bulk)
            region = REG_HEADER;
        else if (kb_idx >= starts.fields.qsnd)
            region = REG_QSND;
        else if (kb_idx >= starts.fields.gfx)
            region = REG_GFX;
        else if (kb_idx >= starts.fields.pcm)
            region = REG_PCM;
        else if (kb_idx >= starts.fields.snd)
            region = REG_SND;
        else
            region = REG_CPU;
    end

    always_comb begin
        reg_start = 16'd0;
        reg_ofs   = `LDR_CPU_OFS;
        bank      = BANK_CPU;
        case (region)
            REG_SND: begin
                reg_start = starts.fields.snd;
                reg_ofs   = `LDR_SND_OFS;
                bank      = BANK_SND;
            end
            REG_PCM: begin
                reg_start = starts.fields.pcm;
                reg_ofs   = `LDR_PCM_OFS;
                bank      = BANK_SND;      // shares the sound bank
            end
            REG_GFX: begin
                reg_start = starts.fields.gfx;
                reg_ofs   = `LDR_GFX_OFS;
                bank      = BANK_GFX;
            end
            REG_QSND: begin
                reg_start = starts.fields.qsnd;
                reg_ofs   = '0;
                bank      = BANK_AUX;
            end
            default: ;
        endcase
    end

    assign rel_addr  = bulk_addr - {reg_start[AW-11:0], 10'd0};
    assign word_addr = rel_addr[PW:1] + reg_ofs;

    // CPU byte decryption
    always_comb begin
        dec_data = 8'h00;
        for (int i = 0; i < 8; i++) begin
            if (ioctl_data[i])
                dec_data = dec_data ^ DEC_XOR[i];
        end
        dec_data = dec_data ^ `LDR_DEC_INV;
    end

    assign dec_hit = dec_en && region == REG_CPU && rel_addr[PW:1] >= `LDR_DEC_CPU_LIMIT
                     && rel_addr[0] == dec_sel;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_push <= 1'b0;
            cfg_we   <= 1'b0;
            dec_en   <= 1'b0;
            dec_sel  <= 1'b0;
            credits  <= CW'(`LDR_QUEUE_DEPTH);
        end else begin
            req_push <= take;
            cfg_we   <= ioctl_wr && is_cfg;
            credits  <= credits - CW'(take) + CW'(credit_ret);
            if (!downloading) begin
                dec_en  <= 1'b0;
                dec_sel <= 1'b0;
            end else if (ioctl_wr && ioctl_addr == CFG_POS) begin
                {dec_en, dec_sel} <= ioctl_data[7:6];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr && is_start)
            starts.bytes <= {ioctl_data, starts.bytes[`LDR_START_BYTES-1:1]};
        if (ioctl_wr && is_cfg) begin
            cfg_addr <= ioctl_addr[$clog2(`LDR_HDR_BYTES)-1:0];
            cfg_data <= ioctl_data;
        end
        if (take) begin
            // PROM is byte wide, so it keeps the byte offset
            req_addr <= region == REG_QSND ? rel_addr[PW-1:0] : word_addr;
            req_data <= dec_hit ? dec_data : ioctl_data;
            req_mask <= rel_addr[0] ? 2'b10 : 2'b01;   // even byte -> high half
            req_bank <= bank;
            req_kind <= region == REG_QSND ? KIND_PROM : KIND_SDRAM;
        end
    end

    assign dl_stall = credits == '0;   // out of credits

    a_credit_max: assert property (@(posedge clk) disable iff (reset)
        credits <= CW'(`LDR_QUEUE_DEPTH));
    a_push_credit: assert property (@(posedge clk) disable iff (reset)
        req_push |-> $past(credits) != '0);

endmodule

`default_nettype wire

// File: rom_layout_pkg.sv
// ROM image layout types
`default_nettype none
`include "loader_defs.svh"

package rom_layout_pkg;

    // where a byte of the downloaded file belongs
    typedef enum logic [2:0] {
        REG_HEADER = 3'd0,
        REG_CPU    = 3'd1,
        REG_SND    = 3'd2,
        REG_PCM    = 3'd3,
        REG_GFX    = 3'd4,
        REG_QSND   = 3'd5
    } region_t;

    // header start table, sent lsb first
    // bytes view for shifting in, fields view for region compare
    typedef union packed {
        logic [`LDR_START_BYTES-1:0][7:0] bytes;
        struct packed {
            logic [15:0] qsnd;  // bytes 6,7
            logic [15:0] gfx;   // bytes 4,5
            logic [15:0] pcm;   // bytes 2,3
            logic [15:0] snd;   // bytes 0,1
        } fields;
    } start_table_u;

endpackage

`default_nettype wire

// File: mem_req_pkg.sv
// memory write request types
`default_nettype none

package mem_req_pkg;

    // SDRAM banks used by the loader
    typedef enum logic [1:0] {
        BANK_AUX = 2'd0,
        BANK_SND = 2'd1,    // sound and PCM
        BANK_GFX = 2'd2,
        BANK_CPU = 2'd3
    } bank_t;

    // request goes to SDRAM or to the Q-sound PROM
    typedef enum logic {
        KIND_SDRAM = 1'b0,
        KIND_PROM  = 1'b1
    } req_kind_t;

endpackage

`default_nettype wire

// File: loader_defs.svh
// ROM loader parameters
`ifndef LOADER_DEFS_SVH
`define LOADER_DEFS_SVH

// image header layout
`define LDR_HDR_BYTES     16
`define LDR_START_BYTES   8
`define LDR_CFG_BYTE      15     // bit 7 decrypt enable, bit 6 odd/even select

// address widths
`define LDR_IOCTL_AW      25     // host byte address, up to 32 MB
`define LDR_PROG_AW       22     // SDRAM word address

`define LDR_QUEUE_DEPTH   4      // queue slots and initial credits

// per-region word offsets in the SDRAM banks
`define LDR_CPU_OFS       22'h0
`define LDR_SND_OFS       22'h0
`define LDR_PCM_OFS       22'h0
`define LDR_GFX_OFS       22'h0

// CPU word address where the encrypted area begins
`define LDR_DEC_CPU_LIMIT 22'h000004

// decryption table, one term per set data bit
`define LDR_DEC_XOR_0     8'h04
`define LDR_DEC_XOR_1     8'h21
`define LDR_DEC_XOR_2     8'h01
`define LDR_DEC_XOR_3     8'h50
`define LDR_DEC_XOR_4     8'h40
`define LDR_DEC_XOR_5     8'h06
`define LDR_DEC_XOR_6     8'h08
`define LDR_DEC_XOR_7     8'h88
`define LDR_DEC_INV       8'hD8  // bits 3 and 7 apply when clear

`endif
